// ==== dv/isaRef.svh ====
`ifndef ISA_REF_SVH
`define ISA_REF_SVH

// Opcodes and R-format function codes
localparam logic [3:0] bneOpc = 4'd0;
localparam logic [3:0] beqOpc = 4'd1;
localparam logic [3:0] bgzOpc = 4'd2;
localparam logic [3:0] blzOpc = 4'd3;
localparam logic [3:0] adiOpc = 4'd4;
localparam logic [3:0] oriOpc = 4'd5;
localparam logic [3:0] lhiOpc = 4'd6;
localparam logic [3:0] lwdOpc = 4'd7;
localparam logic [3:0] swdOpc = 4'd8;
localparam logic [3:0] jmpOpc = 4'd9;
localparam logic [3:0] jalOpc = 4'd10;
localparam logic [3:0] rtypeOpc = 4'd15;

localparam logic [5:0] addFn = 6'd0;
localparam logic [5:0] subFn = 6'd1;
localparam logic [5:0] andFn = 6'd2;
localparam logic [5:0] orrFn = 6'd3;
localparam logic [5:0] notFn = 6'd4;
localparam logic [5:0] tcpFn = 6'd5;
localparam logic [5:0] shlFn = 6'd6;
localparam logic [5:0] shrFn = 6'd7;
localparam logic [5:0] jprFn = 6'd25;
localparam logic [5:0] jrlFn = 6'd26;
localparam logic [5:0] wwdFn = 6'd28;
localparam logic [5:0] hltFn = 6'd29;

// Instruction-level model over imem and refMem, returns the retire count or -1
function automatic int runProgram();
    logic [15:0] r [4];
    logic [15:0] pc, nextPc, ins, a, b, simm, addr;
    int steps;
    for (int i = 0; i < 4; i++) begin
        r[i] = '0;
    end
    pc = 16'(`RESET_PC);
    steps = 0;
    expQ.delete();
    while (steps < 2000) begin
        ins = imem[pc[7:0]];
        steps++;
        a = r[ins[11:10]];
        b = r[ins[9:8]];
        simm = {{8{ins[7]}}, ins[7:0]};
        addr = a + simm;
        nextPc = pc + 16'd1;
        case (ins[15:12])
            bneOpc: if (a != b) nextPc = pc + 16'd1 + simm;
            beqOpc: if (a == b) nextPc = pc + 16'd1 + simm;
            bgzOpc: if ($signed(a) > 0) nextPc = pc + 16'd1 + simm;
            blzOpc: if ($signed(a) < 0) nextPc = pc + 16'd1 + simm;
            adiOpc: r[ins[9:8]] = a + simm;
            oriOpc: r[ins[9:8]] = a | {8'h00, ins[7:0]};
            lhiOpc: r[ins[9:8]] = {ins[7:0], 8'h00};
            lwdOpc: r[ins[9:8]] = refMem[addr[7:0]];
            swdOpc: refMem[addr[7:0]] = b;
            jmpOpc: nextPc = {pc[15:12], ins[11:0]};
            jalOpc: begin
                r[2] = pc + 16'd1;
                nextPc = {pc[15:12], ins[11:0]};
            end
            rtypeOpc: begin
                case (ins[5:0])
                    addFn: r[ins[7:6]] = a + b;
                    subFn: r[ins[7:6]] = a - b;
                    andFn: r[ins[7:6]] = a & b;
                    orrFn: r[ins[7:6]] = a | b;
                    notFn: r[ins[7:6]] = ~a;
                    tcpFn: r[ins[7:6]] = 16'd0 - a;
                    shlFn: r[ins[7:6]] = {a[14:0], 1'b0};
                    shrFn: r[ins[7:6]] = {a[15], a[15:1]};
                    jprFn: nextPc = a;
                    jrlFn: begin
                        r[2] = pc + 16'd1;
                        nextPc = a;
                    end
                    wwdFn: expQ.push_back(a);
                    hltFn: return steps;
                    default: ;
                endcase
            end
            default: ;
        endcase
        pc = nextPc;
    end
    return -1;
endfunction

`endif

// ==== dv/cpuTb.sv ====
`include "cpu_macros.svh"

module cpuTb;
    timeunit 1ns;
    timeprecision 1ps;

    // Value a memory returns while its port is not strobed
    localparam logic [15:0] idleBus = 16'hdead;

    logic        Clk;
    logic        rstN;
    logic        instrRead;
    logic [15:0] instrAddr, instrData;
    logic        dataRead, dataWrite;
    logic [15:0] dataAddr, dataWrData, dataRdData;
    logic        outputValid;
    logic [15:0] outputPort, numInst;
    logic        halted;

    logic [15:0] imem [256];
    logic [15:0] dmem [256];
    logic [15:0] refMem [256];
    logic [15:0] expQ [$];
    int          expCount;
    int          emitPtr;
    string       currentTest;
    bit          armed;
    bit          doneFlag;
    time         budget;

    `include "isaRef.svh"

    cpu DUT (
        .Clk         (Clk),
        .rstN        (rstN),
        .instrRead   (instrRead),
        .instrAddr   (instrAddr),
        .instrData   (instrData),
        .dataRead    (dataRead),
        .dataWrite   (dataWrite),
        .dataAddr    (dataAddr),
        .dataWrData  (dataWrData),
        .dataRdData  (dataRdData),
        .outputValid (outputValid),
        .outputPort  (outputPort),
        .numInst     (numInst),
        .halted      (halted)
    );

    // Both memories answer in the same cycle
    assign instrData  = instrRead ? imem[instrAddr[7:0]] : idleBus;
    assign dataRdData = dataRead ? dmem[dataAddr[7:0]] : idleBus;

    always @(posedge Clk) begin
        if (dataWrite) begin
            dmem[dataAddr[7:0]] <= dataWrData;
        end
    end

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string what, input logic [15:0] exp, input logic [15:0] act);
        if (exp !== act) begin
            $display("MISMATCH test=%s %s expected=%h actual=%h", currentTest, what, exp, act);
            failRun("Value check failed");
        end
    endtask

    function automatic logic [15:0] rInstr(input logic [5:0] fn, input logic [1:0] rs,
                                           input logic [1:0] rt, input logic [1:0] rd);
        return {rtypeOpc, rs, rt, rd, fn};
    endfunction

    function automatic logic [15:0] iInstr(input logic [3:0] op, input logic [1:0] rs,
                                           input logic [1:0] rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] wwd(input logic [1:0] rs);
        return rInstr(wwdFn, rs, 2'd0, 2'd0);
    endfunction

    function automatic logic [15:0] fillWord(input int addr);
        logic [15:0] a;
        a = 16'(addr);
        return (a * 16'h0139) ^ {a[7:0], ~a[7:0]};
    endfunction

    task automatic newProgram();
        for (int i = 0; i < 256; i++) begin
            imem[i] = rInstr(hltFn, 2'd0, 2'd0, 2'd0);
        end
        emitPtr = 0;
    endtask

    task automatic emit(input logic [15:0] w);
        imem[emitPtr[7:0]] = w;
        emitPtr++;
    endtask

    task automatic applyReset();
        @(negedge Clk);
        rstN = 1'b0;
        repeat (4) @(negedge Clk);
        rstN = 1'b1;
    endtask

    task automatic checkResetState();
        checkValue("instrRead after reset", 16'd1, {15'd0, instrRead});
        checkValue("instrAddr after reset", 16'(`RESET_PC), instrAddr);
        checkValue("dataRead after reset", 16'd0, {15'd0, dataRead});
        checkValue("dataWrite after reset", 16'd0, {15'd0, dataWrite});
        checkValue("outputValid after reset", 16'd0, {15'd0, outputValid});
        checkValue("halted after reset", 16'd0, {15'd0, halted});
        checkValue("numInst after reset", 16'd0, numInst);
    endtask

    task automatic runTest(input string name, input bit midReset);
        int count;
        currentTest = name;
        armed = 1'b0;
        doneFlag = 1'b0;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fillWord(i);
            refMem[i] = dmem[i];
        end
        count = runProgram();
        if (count < 0) begin
            failRun($sformatf("Reference model of %s never reached HLT", name));
        end
        expCount = count;
        budget += time'((3 * count + 20) * 8);
        applyReset();
        checkResetState();
        if (midReset) begin
            // Restart once the first instructions have retired
            wait (numInst >= 16'd2);
            applyReset();
            checkResetState();
        end
        armed = 1'b1;
        wait (doneFlag);
    endtask

    // Compares retired outputs and the final state against the reference
    always @(negedge Clk) begin
        if (armed) begin
            if (outputValid) begin
                if (expQ.size() == 0) begin
                    failRun($sformatf("Test %s produced an unexpected output %h",
                                      currentTest, outputPort));
                end else begin
                    checkValue("output", expQ.pop_front(), outputPort);
                end
            end
            if (halted && (dataWrite || dataRead)) begin
                failRun($sformatf("Test %s accessed data memory after halting", currentTest));
            end
            if (halted && !doneFlag) begin
                checkValue("numInst", 16'(expCount), numInst);
                checkValue("instrRead at halt", 16'd0, {15'd0, instrRead});
                for (int i = 0; i < 256; i++) begin
                    checkValue($sformatf("dmem[%0d]", i), refMem[i], dmem[i]);
                end
                if (expQ.size() != 0) begin
                    failRun($sformatf("Test %s halted with %0d outputs missing",
                                      currentTest, expQ.size()));
                end
                doneFlag = 1'b1;
            end
        end
    end

    initial begin
        forever begin
            @(negedge Clk);
            if ($time > budget) begin
                failRun("The processor did not halt in time");
            end
        end
    end

    task automatic buildRandom();
        int kind;
        logic [1:0] rs, rt, rd;
        logic [7:0] imm;
        newProgram();
        for (int r = 0; r < 4; r++) begin
            emit(iInstr(lhiOpc, 2'd0, 2'(r), 8'($urandom)));
            emit(iInstr(oriOpc, 2'(r), 2'(r), 8'($urandom)));
        end
        repeat (28) begin
            kind = int'($urandom_range(0, 12));
            rs = 2'($urandom);
            rt = 2'($urandom);
            rd = 2'($urandom);
            imm = 8'($urandom);
            case (kind)
                8:  emit(iInstr(adiOpc, rs, rt, imm));
                9:  emit(iInstr(lwdOpc, rs, rt, imm));
                10: emit(iInstr(swdOpc, rs, rt, imm));
                11, 12: emit(wwd(rs));
                default: emit(rInstr(6'(kind), rs, rt, rd));
            endcase
        end
        for (int r = 0; r < 4; r++) begin
            emit(wwd(2'(r)));
        end
        emit(rInstr(hltFn, 2'd0, 2'd0, 2'd0));
    endtask

    initial begin
        rstN = 1'b0;
        armed = 1'b0;
        doneFlag = 1'b0;
        budget = 200;
        void'($urandom(32'h54e63081));
        newProgram();
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fillWord(i);
        end

        // ALU chains with back-to-back dependencies
        newProgram();
        emit(iInstr(lhiOpc, 2'd0, 2'd0, 8'h12));
        emit(iInstr(oriOpc, 2'd0, 2'd0, 8'hb4));
        emit(wwd(2'd0));
        emit(iInstr(adiOpc, 2'd0, 2'd1, 8'hfb));
        emit(rInstr(addFn, 2'd0, 2'd1, 2'd2));
        emit(rInstr(subFn, 2'd2, 2'd0, 2'd3));
        emit(wwd(2'd3));
        emit(rInstr(andFn, 2'd3, 2'd2, 2'd1));
        emit(rInstr(orrFn, 2'd1, 2'd0, 2'd2));
        emit(wwd(2'd2));
        emit(rInstr(notFn, 2'd2, 2'd0, 2'd3));
        emit(rInstr(tcpFn, 2'd3, 2'd0, 2'd0));
        emit(wwd(2'd0));
        emit(rInstr(shlFn, 2'd0, 2'd0, 2'd1));
        emit(rInstr(shrFn, 2'd1, 2'd0, 2'd2));
        emit(wwd(2'd1));
        emit(wwd(2'd2));
        emit(iInstr(lhiOpc, 2'd0, 2'd3, 8'h80));
        emit(rInstr(shrFn, 2'd3, 2'd0, 2'd3));
        emit(wwd(2'd3));
        emit(rInstr(hltFn, 2'd0, 2'd0, 2'd0));
        runTest("aluForward", 1'b0);

        // Load-use stalls and stores of forwarded data
        newProgram();
        emit(iInstr(adiOpc, 2'd0, 2'd0, 8'h10));
        emit(iInstr(lwdOpc, 2'd0, 2'd1, 8'h00));
        emit(rInstr(addFn, 2'd1, 2'd1, 2'd2));
        emit(wwd(2'd2));
        emit(iInstr(adiOpc, 2'd2, 2'd3, 8'h07));
        emit(iInstr(swdOpc, 2'd0, 2'd3, 8'h01));
        emit(iInstr(lwdOpc, 2'd0, 2'd1, 8'h01));
        emit(wwd(2'd1));
        emit(iInstr(lwdOpc, 2'd0, 2'd2, 8'h02));
        emit(iInstr(swdOpc, 2'd0, 2'd2, 8'h03));
        emit(iInstr(lwdOpc, 2'd0, 2'd3, 8'h03));
        emit(wwd(2'd3));
        emit(iInstr(lwdOpc, 2'd0, 2'd1, 8'hff));
        emit(wwd(2'd1));
        emit(rInstr(hltFn, 2'd0, 2'd0, 2'd0));
        runTest("loadStore", 1'b0);

        // Branches and JMP with wrong-path WWDs behind each redirect
        newProgram();
        emit(iInstr(adiOpc, 2'd0, 2'd0, 8'h03));
        emit(iInstr(adiOpc, 2'd1, 2'd1, 8'hfe));
        emit(iInstr(bneOpc, 2'd0, 2'd1, 8'h02));
        emit(wwd(2'd0));
        emit(wwd(2'd1));
        emit(iInstr(beqOpc, 2'd0, 2'd1, 8'h01));
        emit(wwd(2'd0));
        emit(iInstr(bgzOpc, 2'd0, 2'd0, 8'h01));
        emit(wwd(2'd1));
        emit(iInstr(blzOpc, 2'd0, 2'd0, 8'h01));
        emit(iInstr(blzOpc, 2'd1, 2'd0, 8'h01));
        emit(wwd(2'd0));
        emit({jmpOpc, 12'd15});
        emit(wwd(2'd0));
        emit(wwd(2'd1));
        emit(iInstr(bgzOpc, 2'd1, 2'd0, 8'h01));
        emit(wwd(2'd1));
        emit(iInstr(adiOpc, 2'd0, 2'd0, 8'hff));
        emit(iInstr(bneOpc, 2'd0, 2'd2, 8'hfe));
        emit(wwd(2'd0));
        emit(rInstr(hltFn, 2'd0, 2'd0, 2'd0));
        runTest("controlFlow", 1'b0);

        // Calls and returns through JAL, JRL and JPR
        newProgram();
        emit({jalOpc, 12'd6});
        emit(wwd(2'd2));
        emit(iInstr(adiOpc, 2'd3, 2'd3, 8'd10));
        emit(rInstr(jrlFn, 2'd3, 2'd0, 2'd0));
        emit(wwd(2'd2));
        emit(rInstr(hltFn, 2'd0, 2'd0, 2'd0));
        emit(wwd(2'd2));
        emit(rInstr(jprFn, 2'd2, 2'd0, 2'd0));
        emit(wwd(2'd0));
        emit(wwd(2'd0));
        emit(wwd(2'd2));
        emit(rInstr(jprFn, 2'd2, 2'd0, 2'd0));
        emit(wwd(2'd0));
        runTest("links", 1'b0);

        for (int t = 0; t < 4; t++) begin
            buildRandom();
            runTest($sformatf("random%0d", t), 1'b0);
        end

        // Nothing after HLT may retire
        newProgram();
        emit(iInstr(adiOpc, 2'd0, 2'd0, 8'h05));
        emit(wwd(2'd0));
        emit(iInstr(swdOpc, 2'd1, 2'd0, 8'h20));
        emit(rInstr(hltFn, 2'd0, 2'd0, 2'd0));
        emit(wwd(2'd0));
        emit(iInstr(swdOpc, 2'd1, 2'd0, 8'h21));
        runTest("halt", 1'b0);
        repeat (20) @(negedge Clk);
        checkValue("halted held", 16'd1, {15'd0, halted});
        checkValue("numInst held", 16'(expCount), numInst);
        runTest("midRunReset", 1'b1);

        $display("Everything OK");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+rtl
+incdir+dv
rtl/cpuPkg.sv
rtl/regFile.sv
rtl/controlUnit.sv
rtl/alu.sv
rtl/hazardUnit.sv
rtl/datapath.sv
rtl/cpu.sv
dv/cpuTb.sv

// ==== rtl/alu.sv ====
`include "cpu_macros.svh"

module alu import cpuPkg::*; (
    input  opcodeT                opcode,
    input  funcT                  func,
    input  logic [`WORD_SIZE-1:0] a,
    input  logic [`WORD_SIZE-1:0] b,
    output logic [`WORD_SIZE-1:0] result,
    output logic                  branchTaken
);

    aluOpT                 op;
    logic [`WORD_SIZE-1:0] bEff;

    // ORI takes its immediate zero-extended
    assign bEff = (opcode == opOri) ? {{(`WORD_SIZE-8){1'b0}}, b[7:0]} : b;

    always_comb begin
        case (opcode)
            opRtype: begin
                case (func)
                    fnAdd:   op = aluAdd;
                    fnSub:   op = aluSub;
                    fnAnd:   op = aluAnd;
                    fnOrr:   op = aluOr;
                    fnNot:   op = aluNot;
                    fnTcp:   op = aluNeg;
                    fnShl:   op = aluShl;
                    fnShr:   op = aluShr;
                    default: op = aluPassA;
                endcase
            end
            opAdi, opLwd, opSwd:        op = aluAdd;
            opOri:                      op = aluOr;
            opLhi:                      op = aluLhi;
            opBne, opBeq, opBgz, opBlz: op = aluSub;
            default:                    op = aluPassA;
        endcase
    end

    always_comb begin
        case (op)
            aluAdd:  result = a + bEff;
            aluSub:  result = a - bEff;
            aluAnd:  result = a & bEff;
            aluOr:   result = a | bEff;
            aluNot:  result = ~a;
            aluNeg:  result = -a;
            aluShl:  result = {a[`WORD_SIZE-2:0], 1'b0};
            aluShr:  result = {a[`WORD_SIZE-1], a[`WORD_SIZE-1:1]};
            aluLhi:  result = {bEff[7:0], {(`WORD_SIZE-8){1'b0}}};
            default: result = a;
        endcase
    end

    always_comb begin
        case (opcode)
            opBne:   branchTaken = (a != b);
            opBeq:   branchTaken = (a == b);
            opBgz:   branchTaken = ($signed(a) > 0);
            opBlz:   branchTaken = ($signed(a) < 0);
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

// ==== rtl/controlUnit.sv ====
`include "cpu_macros.svh"

module controlUnit import cpuPkg::*; (
    input  logic [`WORD_SIZE-1:0] instr,
    output ctrlT                  ctrl
);

    opcodeT opcode;
    funcT   func;

    assign opcode = opcodeT'(instr[15:12]);
    assign func   = funcT'(instr[5:0]);

    // Unknown encodings fall through as a NOP
    always_comb begin
        ctrl = '0;
        case (opcode)
            opBne, opBeq: begin
                ctrl.isBranch = 1'b1;
                ctrl.useRs    = 1'b1;
                ctrl.useRt    = 1'b1;
            end
            opBgz, opBlz: begin
                ctrl.isBranch = 1'b1;
                ctrl.useRs    = 1'b1;
            end
            opAdi, opOri, opLhi, opLwd: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.isAlu    = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.useRs    = (opcode != opLhi);
                ctrl.memRead  = (opcode == opLwd);
                ctrl.memToReg = (opcode == opLwd);
            end
            opSwd: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.isAlu    = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.useRs    = 1'b1;
                ctrl.useRt    = 1'b1;
            end
            opJmp, opJal: begin
                ctrl.isJumpImm = 1'b1;
                ctrl.isLink    = (opcode == opJal);
                ctrl.regWrite  = (opcode == opJal);
            end
            opRtype: begin
                case (func)
                    fnAdd, fnSub, fnAnd, fnOrr, fnNot, fnTcp, fnShl, fnShr: begin
                        ctrl.isAlu    = 1'b1;
                        ctrl.regDst   = 1'b1;
                        ctrl.regWrite = 1'b1;
                        ctrl.useRs    = 1'b1;
                        ctrl.useRt    = (func inside {fnAdd, fnSub, fnAnd, fnOrr});
                    end
                    fnWwd: begin
                        ctrl.isAlu = 1'b1;
                        ctrl.isWwd = 1'b1;
                        ctrl.useRs = 1'b1;
                    end
                    fnJpr, fnJrl: begin
                        ctrl.isJumpReg = 1'b1;
                        ctrl.useRs     = 1'b1;
                        ctrl.isLink    = (func == fnJrl);
                        ctrl.regWrite  = (func == fnJrl);
                    end
                    fnHlt: ctrl.isHalt = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

// ==== rtl/cpu.sv ====
`include "cpu_macros.svh"

module cpu import cpuPkg::*; (
    input  logic                  Clk,
    input  logic                  rstN,
    output logic                  instrRead,
    output logic [`WORD_SIZE-1:0] instrAddr,
    input  logic [`WORD_SIZE-1:0] instrData,
    output logic                  dataRead,
    output logic                  dataWrite,
    output logic [`WORD_SIZE-1:0] dataAddr,
    output logic [`WORD_SIZE-1:0] dataWrData,
    input  logic [`WORD_SIZE-1:0] dataRdData,
    output logic                  outputValid,
    output logic [`WORD_SIZE-1:0] outputPort,
    output logic [`WORD_SIZE-1:0] numInst,
    output logic                  halted
);

    logic [`WORD_SIZE-1:0] idInstr;
    ctrlT                  idCtrl;

    controlUnit uControl (
        .instr (idInstr),
        .ctrl  (idCtrl)
    );

    datapath uDatapath (
        .Clk         (Clk),
        .rstN        (rstN),
        .idInstr     (idInstr),
        .idCtrl      (idCtrl),
        .instrRead   (instrRead),
        .instrAddr   (instrAddr),
        .instrData   (instrData),
        .dataRead    (dataRead),
        .dataWrite   (dataWrite),
        .dataAddr    (dataAddr),
        .dataWrData  (dataWrData),
        .dataRdData  (dataRdData),
        .outputValid (outputValid),
        .outputPort  (outputPort),
        .numInst     (numInst),
        .halted      (halted)
    );

endmodule

// ==== rtl/cpuPkg.sv ====
`include "cpu_macros.svh"

package cpuPkg;

    typedef enum logic [3:0] {
        opBne   = 4'd0,
        opBeq   = 4'd1,
        opBgz   = 4'd2,
        opBlz   = 4'd3,
        opAdi   = 4'd4,
        opOri   = 4'd5,
        opLhi   = 4'd6,
        opLwd   = 4'd7,
        opSwd   = 4'd8,
        opJmp   = 4'd9,
        opJal   = 4'd10,
        opRtype = 4'd15
    } opcodeT;

    // R-format function field
    typedef enum logic [5:0] {
        fnAdd = 6'd0,
        fnSub = 6'd1,
        fnAnd = 6'd2,
        fnOrr = 6'd3,
        fnNot = 6'd4,
        fnTcp = 6'd5,
        fnShl = 6'd6,
        fnShr = 6'd7,
        fnJpr = 6'd25,
        fnJrl = 6'd26,
        fnWwd = 6'd28,
        fnHlt = 6'd29
    } funcT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluNot,
        aluNeg,
        aluShl,
        aluShr,
        aluPassA,
        aluLhi
    } aluOpT;

    typedef enum logic [1:0] {
        fwdNone = 2'd0,
        fwdMem  = 2'd1,
        fwdWb   = 2'd2
    } fwdSelT;

    typedef struct packed {
        logic regDst, aluSrc, isAlu;
        logic isBranch, isJumpReg, isJumpImm, isLink;
        logic memRead, memWrite, memToReg, regWrite;
        logic isWwd, isHalt;
        // Source registers the instruction really reads
        logic useRs, useRt;
    } ctrlT;

    typedef struct packed {
        logic                  valid;
        logic [`WORD_SIZE-1:0] pc;
        logic [`WORD_SIZE-1:0] instr;
    } ifIdT;

    typedef struct packed {
        logic                  valid;
        ctrlT                  ctrl;
        logic [`WORD_SIZE-1:0] pc;
        opcodeT                opcode;
        funcT                  func;
        logic [1:0]            rs, rt, rd;
        logic [`WORD_SIZE-1:0] opA, opB;
        logic [`WORD_SIZE-1:0] imm;
    } idExT;

    typedef struct packed {
        logic                  valid;
        logic                  memRead, memWrite, memToReg, regWrite;
        logic                  isWwd, isHalt;
        logic [`WORD_SIZE-1:0] aluResult;
        logic [`WORD_SIZE-1:0] storeData;
        logic [1:0]            rd;
    } exMemT;

    typedef struct packed {
        logic                  valid;
        logic                  memToReg, regWrite;
        logic                  isWwd, isHalt;
        logic [`WORD_SIZE-1:0] aluResult;
        logic [`WORD_SIZE-1:0] loadData;
        logic [1:0]            rd;
    } memWbT;

endpackage

// ==== rtl/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data and address width
`define WORD_SIZE 16

`define REG_COUNT 4

// Register written by JAL and JRL
`define LINK_REG 2

`define RESET_PC 0

`endif

// ==== rtl/datapath.sv ====
`include "cpu_macros.svh"

module datapath import cpuPkg::*; (
    input  logic                  Clk,
    input  logic                  rstN,
    output logic [`WORD_SIZE-1:0] idInstr,
    input  ctrlT                  idCtrl,
    output logic                  instrRead,
    output logic [`WORD_SIZE-1:0] instrAddr,
    input  logic [`WORD_SIZE-1:0] instrData,
    output logic                  dataRead,
    output logic                  dataWrite,
    output logic [`WORD_SIZE-1:0] dataAddr,
    output logic [`WORD_SIZE-1:0] dataWrData,
    input  logic [`WORD_SIZE-1:0] dataRdData,
    output logic                  outputValid,
    output logic [`WORD_SIZE-1:0] outputPort,
    output logic [`WORD_SIZE-1:0] numInst,
    output logic                  halted
);

    ifIdT  ifId;
    idExT  idEx;
    exMemT exMem;
    memWbT memWb;

    logic [`WORD_SIZE-1:0] pc;
    logic                  fetchStop;

    ctrlT                  idCtrlV;
    logic [1:0]            idRs, idRt, idRd;
    logic [`WORD_SIZE-1:0] idRegA, idRegB, idImm, jumpTarget;
    logic                  idJump, idHalt, stall;

    fwdSelT                fwdA, fwdB;
    logic [`WORD_SIZE-1:0] exA, exB, aluB, aluResult, exResult, exTarget;
    logic                  branchTaken, exRedirect;
    logic [`WORD_SIZE-1:0] wbData;

    // ID stage
    assign idInstr    = ifId.instr;
    assign idCtrlV    = ifId.valid ? idCtrl : '0;
    assign idRs       = ifId.instr[11:10];
    assign idRt       = ifId.instr[9:8];
    assign idRd       = idCtrl.isLink ? 2'(`LINK_REG) :
                        (idCtrl.regDst ? ifId.instr[7:6] : idRt);
    assign idImm      = {{(`WORD_SIZE-8){ifId.instr[7]}}, ifId.instr[7:0]};
    assign jumpTarget = {ifId.pc[`WORD_SIZE-1:12], ifId.instr[11:0]};
    assign idJump     = idCtrlV.isJumpImm;
    assign idHalt     = idCtrlV.isHalt;

    regFile uRegFile (
        .Clk       (Clk),
        .rstN      (rstN),
        .readAddrA (idRs),
        .readAddrB (idRt),
        .readDataA (idRegA),
        .readDataB (idRegB),
        .writeEn   (memWb.valid && memWb.regWrite),
        .writeAddr (memWb.rd),
        .writeData (wbData)
    );

    hazardUnit uHazard (
        .idRs        (idRs),
        .idRt        (idRt),
        .idCtrl      (idCtrlV),
        .exRs        (idEx.rs),
        .exRt        (idEx.rt),
        .exRd        (idEx.rd),
        .exMemRead   (idEx.ctrl.memRead),
        .exValid     (idEx.valid),
        .memRd       (exMem.rd),
        .memRegWrite (exMem.regWrite),
        .memValid    (exMem.valid),
        .wbRd        (memWb.rd),
        .wbRegWrite  (memWb.regWrite),
        .wbValid     (memWb.valid),
        .fwdA        (fwdA),
        .fwdB        (fwdB),
        .stall       (stall)
    );

    // EX stage
    always_comb begin
        case (fwdA)
            fwdMem:  exA = exMem.aluResult;
            fwdWb:   exA = wbData;
            default: exA = idEx.opA;
        endcase
        case (fwdB)
            fwdMem:  exB = exMem.aluResult;
            fwdWb:   exB = wbData;
            default: exB = idEx.opB;
        endcase
    end

    assign aluB = idEx.ctrl.aluSrc ? idEx.imm : exB;

    alu uAlu (
        .opcode      (idEx.opcode),
        .func        (idEx.func),
        .a           (exA),
        .b           (aluB),
        .result      (aluResult),
        .branchTaken (branchTaken)
    );

    // Non-ALU results are the link address
    assign exResult   = idEx.ctrl.isAlu ? aluResult : idEx.pc + `WORD_SIZE'(1);
    assign exRedirect = idEx.valid &&
                        ((idEx.ctrl.isBranch && branchTaken) || idEx.ctrl.isJumpReg);
    assign exTarget   = idEx.ctrl.isJumpReg ? exA : idEx.pc + `WORD_SIZE'(1) + idEx.imm;

    assign wbData = memWb.memToReg ? memWb.loadData : memWb.aluResult;

    // Memory ports
    assign instrRead  = !fetchStop;
    assign instrAddr  = pc;
    assign dataRead   = exMem.valid && exMem.memRead;
    assign dataWrite  = exMem.valid && exMem.memWrite;
    assign dataAddr   = exMem.aluResult;
    assign dataWrData = exMem.storeData;

    // PC priority is stall, EX redirect, ID jump, halt, increment
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            pc        <= `WORD_SIZE'(`RESET_PC);
            fetchStop <= 1'b0;
        end else begin
            if (!stall) begin
                if (exRedirect) begin
                    pc <= exTarget;
                end else if (idJump) begin
                    pc <= jumpTarget;
                end else if (!(idHalt || fetchStop)) begin
                    pc <= pc + `WORD_SIZE'(1);
                end
            end
            if (idHalt && !stall && !exRedirect) begin
                fetchStop <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            ifId.valid  <= 1'b0;
            idEx.valid  <= 1'b0;
            exMem.valid <= 1'b0;
            memWb.valid <= 1'b0;
        end else begin
            if (!stall) begin
                ifId.valid <= !(exRedirect || idJump || idHalt || fetchStop);
                ifId.pc    <= pc;
                ifId.instr <= instrData;
            end

            idEx.valid  <= ifId.valid && !stall && !exRedirect;
            idEx.ctrl   <= idCtrl;
            idEx.pc     <= ifId.pc;
            idEx.opcode <= opcodeT'(ifId.instr[15:12]);
            idEx.func   <= funcT'(ifId.instr[5:0]);
            idEx.rs     <= idRs;
            idEx.rt     <= idRt;
            idEx.rd     <= idRd;
            idEx.opA    <= idRegA;
            idEx.opB    <= idRegB;
            idEx.imm    <= idImm;

            exMem.valid     <= idEx.valid;
            exMem.memRead   <= idEx.ctrl.memRead;
            exMem.memWrite  <= idEx.ctrl.memWrite;
            exMem.memToReg  <= idEx.ctrl.memToReg;
            exMem.regWrite  <= idEx.ctrl.regWrite;
            exMem.isWwd     <= idEx.ctrl.isWwd;
            exMem.isHalt    <= idEx.ctrl.isHalt;
            exMem.aluResult <= exResult;
            exMem.storeData <= exB;
            exMem.rd        <= idEx.rd;

            memWb.valid     <= exMem.valid;
            memWb.memToReg  <= exMem.memToReg;
            memWb.regWrite  <= exMem.regWrite;
            memWb.isWwd     <= exMem.isWwd;
            memWb.isHalt    <= exMem.isHalt;
            memWb.aluResult <= exMem.aluResult;
            memWb.loadData  <= dataRdData;
            memWb.rd        <= exMem.rd;
        end
    end

    // Retire
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            numInst     <= '0;
            halted      <= 1'b0;
            outputValid <= 1'b0;
        end else begin
            outputValid <= memWb.valid && memWb.isWwd;
            if (memWb.valid) begin
                numInst <= numInst + `WORD_SIZE'(1);
            end
            if (memWb.valid && memWb.isHalt) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (memWb.valid && memWb.isWwd) begin
            outputPort <= memWb.aluResult;
        end
    end

endmodule

// ==== rtl/hazardUnit.sv ====
module hazardUnit import cpuPkg::*; (
    input  logic [1:0] idRs,
    input  logic [1:0] idRt,
    input  ctrlT       idCtrl,
    input  logic [1:0] exRs,
    input  logic [1:0] exRt,
    input  logic [1:0] exRd,
    input  logic       exMemRead,
    input  logic       exValid,
    input  logic [1:0] memRd,
    input  logic       memRegWrite,
    input  logic       memValid,
    input  logic [1:0] wbRd,
    input  logic       wbRegWrite,
    input  logic       wbValid,
    output fwdSelT     fwdA,
    output fwdSelT     fwdB,
    output logic       stall
);

    // The younger producer in MEM wins over WB
    function automatic fwdSelT pickSource(input logic [1:0] src);
        if (memValid && memRegWrite && memRd == src) begin
            return fwdMem;
        end else if (wbValid && wbRegWrite && wbRd == src) begin
            return fwdWb;
        end
        return fwdNone;
    endfunction

    assign fwdA = pickSource(exRs);
    assign fwdB = pickSource(exRt);

    // Load in EX feeding the instruction in ID
    assign stall = exValid && exMemRead &&
                   ((idCtrl.useRs && idRs == exRd) || (idCtrl.useRt && idRt == exRd));

endmodule

// ==== rtl/regFile.sv ====
`include "cpu_macros.svh"

module regFile (
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic [1:0]            readAddrA,
    input  logic [1:0]            readAddrB,
    output logic [`WORD_SIZE-1:0] readDataA,
    output logic [`WORD_SIZE-1:0] readDataB,
    input  logic                  writeEn,
    input  logic [1:0]            writeAddr,
    input  logic [`WORD_SIZE-1:0] writeData
);

    logic [`WORD_SIZE-1:0] regs [`REG_COUNT];

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeAddr] <= writeData;
        end
    end

    // WB write is visible to the ID read in the same cycle
    assign readDataA = (writeEn && writeAddr == readAddrA) ? writeData : regs[readAddrA];
    assign readDataB = (writeEn && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -f files.f --top-module cpuTb -o simv > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/simv > sim.log 2>&1
! grep -q "Something failed" sim.log && grep -q "Everything OK" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL, see sim.log"; exit 1; }
